//--- alu_defs.svh
`ifndef ALU_DEFS_SVH
`define ALU_DEFS_SVH

// Datapath widths
`define ALU_OP_W    8
`define ALU_RES_W   (`ALU_OP_W + 1)     // One extra bit for carry or borrow
`define ALU_CMD_W   4

// INP_VALID codes
`define ALU_INP_A   2'b01
`define ALU_INP_B   2'b10
`define ALU_INP_AB  2'b11

// Enabled cycles from issue to RES_VALID
`define ALU_LATENCY 2

`endif

//--- alu_pkg.sv
`include "alu_defs.svh"

package alu_pkg;

  // Arithmetic opcodes, used when MODE is 1
  typedef enum logic [`ALU_CMD_W-1:0] {
    ADD     = 4'd0,
    SUB     = 4'd1,
    ADD_CIN = 4'd2,
    SUB_CIN = 4'd3,
    INC_A   = 4'd4,
    DEC_A   = 4'd5,
    INC_B   = 4'd6,
    DEC_B   = 4'd7,
    CMP     = 4'd8
  } arith_op_e;

  // Logical opcodes, used when MODE is 0
  typedef enum logic [`ALU_CMD_W-1:0] {
    AND    = 4'd0,
    NAND   = 4'd1,
    OR     = 4'd2,
    NOR    = 4'd3,
    XOR    = 4'd4,
    XNOR   = 4'd5,
    NOT_A  = 4'd6,
    NOT_B  = 4'd7,
    SHR1_A = 4'd8,
    SHL1_A = 4'd9,
    SHR1_B = 4'd10,
    SHL1_B = 4'd11
  } logic_op_e;

  // Operand set an opcode requires, encoded like INP_VALID
  typedef enum logic [1:0] {
    NEED_A  = `ALU_INP_A,
    NEED_B  = `ALU_INP_B,
    NEED_AB = `ALU_INP_AB
  } operand_need_e;

endpackage

//--- alu_operand_stage.sv
`timescale 1ns/10ps
`include "alu_defs.svh"

module alu_operand_stage (
  input  logic                  CLK,
  input  logic                  RST,
  input  logic                  CE,
  input  logic                  MODE,
  input  logic [`ALU_CMD_W-1:0] CMD,
  input  logic [1:0]            INP_VALID,
  input  logic [`ALU_OP_W-1:0]  OPA,
  input  logic [`ALU_OP_W-1:0]  OPB,
  input  logic                  CIN,
  output logic                  s1_valid,
  output logic                  s1_mode,
  output logic [`ALU_CMD_W-1:0] s1_cmd,
  output logic [`ALU_OP_W-1:0]  s1_a,
  output logic [`ALU_OP_W-1:0]  s1_b,
  output logic                  s1_cin,
  output logic                  s1_err
);

  alu_pkg::operand_need_e need;
  logic                   cmd_ok;
  logic                   err_d;

  always_comb begin
    need   = alu_pkg::NEED_AB;
    cmd_ok = 1'b1;
    if (MODE) begin
      case (alu_pkg::arith_op_e'(CMD))
        alu_pkg::ADD, alu_pkg::SUB, alu_pkg::ADD_CIN, alu_pkg::SUB_CIN,
        alu_pkg::CMP:                     need = alu_pkg::NEED_AB;
        alu_pkg::INC_A, alu_pkg::DEC_A:   need = alu_pkg::NEED_A;
        alu_pkg::INC_B, alu_pkg::DEC_B:   need = alu_pkg::NEED_B;
        default:                          cmd_ok = 1'b0;   // Opcodes 9 to 15
      endcase
    end else begin
      case (alu_pkg::logic_op_e'(CMD))
        alu_pkg::AND, alu_pkg::NAND, alu_pkg::OR, alu_pkg::NOR,
        alu_pkg::XOR, alu_pkg::XNOR:      need = alu_pkg::NEED_AB;
        alu_pkg::NOT_A, alu_pkg::SHR1_A,
        alu_pkg::SHL1_A:                  need = alu_pkg::NEED_A;
        alu_pkg::NOT_B, alu_pkg::SHR1_B,
        alu_pkg::SHL1_B:                  need = alu_pkg::NEED_B;
        default:                          cmd_ok = 1'b0;   // Opcodes 12 to 15
      endcase
    end
  end

  // INP_VALID must name exactly the operands the opcode uses
  assign err_d = !cmd_ok || (INP_VALID != need);

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      s1_valid <= 1'b0;
      s1_mode  <= 1'b0;
      s1_cmd   <= '0;
      s1_err   <= 1'b0;
    end else if (CE) begin
      s1_valid <= 1'b1;   // Each enabled edge is an issue
      s1_mode  <= MODE;
      s1_cmd   <= CMD;
      s1_err   <= err_d;
    end
  end

  always_ff @(posedge CLK) begin
    if (CE) begin
      s1_a   <= OPA;
      s1_b   <= OPB;
      s1_cin <= CIN;
    end
  end

  a_legal_cmd: assert property (@(posedge CLK) disable iff (RST)
    (s1_valid && !s1_err) |->
      (s1_mode ? (s1_cmd <= alu_pkg::CMP) : (s1_cmd <= alu_pkg::SHL1_B)));

endmodule

//--- alu_arith_unit.sv
`timescale 1ns/10ps
`include "alu_defs.svh"

module alu_arith_unit (
  input  logic [`ALU_CMD_W-1:0] s1_cmd,
  input  logic [`ALU_OP_W-1:0]  s1_a,
  input  logic [`ALU_OP_W-1:0]  s1_b,
  input  logic                  s1_cin,
  output logic [`ALU_RES_W-1:0] arith_res,
  output logic                  arith_cout,
  output logic                  arith_oflow,
  output logic                  arith_g,
  output logic                  arith_l,
  output logic                  arith_e
);

  logic [`ALU_RES_W-1:0] a_x;
  logic [`ALU_RES_W-1:0] b_x;
  logic [`ALU_RES_W-1:0] cin_x;

  // Zero-extended operands so the top bit catches carry or borrow
  assign a_x   = {1'b0, s1_a};
  assign b_x   = {1'b0, s1_b};
  assign cin_x = {{(`ALU_RES_W-1){1'b0}}, s1_cin};

  always_comb begin
    arith_res   = '0;
    arith_cout  = 1'b0;
    arith_oflow = 1'b0;
    arith_g     = 1'b0;
    arith_l     = 1'b0;
    arith_e     = 1'b0;
    case (alu_pkg::arith_op_e'(s1_cmd))
      alu_pkg::ADD: begin
        arith_res  = a_x + b_x;
        arith_cout = arith_res[`ALU_RES_W-1];
      end
      alu_pkg::SUB: begin
        arith_res   = a_x - b_x;
        arith_oflow = (a_x < b_x);   // Borrow
      end
      alu_pkg::ADD_CIN: begin
        arith_res  = a_x + b_x + cin_x;
        arith_cout = arith_res[`ALU_RES_W-1];
      end
      alu_pkg::SUB_CIN: begin
        arith_res   = a_x - b_x - cin_x;
        arith_oflow = (a_x < (b_x + cin_x));
      end
      alu_pkg::INC_A: begin
        arith_res   = a_x + 1'b1;
        arith_oflow = arith_res[`ALU_RES_W-1];
      end
      alu_pkg::DEC_A: begin
        arith_res   = a_x - 1'b1;
        arith_oflow = arith_res[`ALU_RES_W-1];   // Set when A was zero
      end
      alu_pkg::INC_B: begin
        arith_res   = b_x + 1'b1;
        arith_oflow = arith_res[`ALU_RES_W-1];
      end
      alu_pkg::DEC_B: begin
        arith_res   = b_x - 1'b1;
        arith_oflow = arith_res[`ALU_RES_W-1];
      end
      alu_pkg::CMP: begin
        arith_g = (s1_a > s1_b);
        arith_l = (s1_a < s1_b);
        arith_e = (s1_a == s1_b);
      end
      default: ;
    endcase
  end

endmodule

//--- alu_logic_unit.sv
`timescale 1ns/10ps
`include "alu_defs.svh"

module alu_logic_unit (
  input  logic [`ALU_CMD_W-1:0] s1_cmd,
  input  logic [`ALU_OP_W-1:0]  s1_a,
  input  logic [`ALU_OP_W-1:0]  s1_b,
  output logic [`ALU_RES_W-1:0] logic_res
);

  logic [`ALU_OP_W-1:0] bit_res;   // Operand-width result before extension
  logic                 top_bit;

  always_comb begin
    bit_res = '0;
    top_bit = 1'b0;
    case (alu_pkg::logic_op_e'(s1_cmd))
      alu_pkg::AND:    bit_res = s1_a & s1_b;
      alu_pkg::NAND:   bit_res = ~(s1_a & s1_b);
      alu_pkg::OR:     bit_res = s1_a | s1_b;
      alu_pkg::NOR:    bit_res = ~(s1_a | s1_b);
      alu_pkg::XOR:    bit_res = s1_a ^ s1_b;
      alu_pkg::XNOR:   bit_res = ~(s1_a ^ s1_b);
      alu_pkg::NOT_A:  bit_res = ~s1_a;
      alu_pkg::NOT_B:  bit_res = ~s1_b;
      alu_pkg::SHR1_A: bit_res = s1_a >> 1;
      alu_pkg::SHR1_B: bit_res = s1_b >> 1;
      alu_pkg::SHL1_A: begin
        bit_res = s1_a << 1;
        top_bit = s1_a[`ALU_OP_W-1];   // Shifted-out MSB
      end
      alu_pkg::SHL1_B: begin
        bit_res = s1_b << 1;
        top_bit = s1_b[`ALU_OP_W-1];
      end
      default: ;
    endcase
  end

  assign logic_res = {top_bit, bit_res};

endmodule

//--- alu_result_stage.sv
`timescale 1ns/10ps
`include "alu_defs.svh"

module alu_result_stage (
  input  logic                  CLK,
  input  logic                  RST,
  input  logic                  CE,
  input  logic                  s1_valid,
  input  logic                  s1_mode,
  input  logic                  s1_err,
  input  logic [`ALU_RES_W-1:0] arith_res,
  input  logic                  arith_cout,
  input  logic                  arith_oflow,
  input  logic                  arith_g,
  input  logic                  arith_l,
  input  logic                  arith_e,
  input  logic [`ALU_RES_W-1:0] logic_res,
  output logic                  RES_VALID,
  output logic [`ALU_RES_W-1:0] RES,
  output logic                  ERR,
  output logic                  COUT,
  output logic                  OFLOW,
  output logic                  G,
  output logic                  L,
  output logic                  E
);

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      RES_VALID <= 1'b0;
      RES       <= '0;
      ERR       <= 1'b0;
      COUT      <= 1'b0;
      OFLOW     <= 1'b0;
      G         <= 1'b0;
      L         <= 1'b0;
      E         <= 1'b0;
    end else if (CE) begin
      RES_VALID <= s1_valid;
      RES       <= '0;   // Cleared unless a good result is present
      ERR       <= s1_valid && s1_err;
      COUT      <= 1'b0;
      OFLOW     <= 1'b0;
      G         <= 1'b0;
      L         <= 1'b0;
      E         <= 1'b0;
      if (s1_valid && !s1_err) begin
        if (s1_mode) begin
          RES   <= arith_res;
          COUT  <= arith_cout;
          OFLOW <= arith_oflow;
          G     <= arith_g;
          L     <= arith_l;
          E     <= arith_e;
        end else begin
          RES <= logic_res;   // Logic ops raise no flags
        end
      end
    end
  end

  a_cmp_onehot: assert property (@(posedge CLK) disable iff (RST) $onehot0({G, L, E}));

endmodule

//--- alu_top.sv
`timescale 1ns/10ps
`include "alu_defs.svh"

module alu_top (
  input  logic                  CLK,
  input  logic                  RST,
  input  logic                  CE,
  input  logic                  MODE,
  input  logic [`ALU_CMD_W-1:0] CMD,
  input  logic [1:0]            INP_VALID,
  input  logic [`ALU_OP_W-1:0]  OPA,
  input  logic [`ALU_OP_W-1:0]  OPB,
  input  logic                  CIN,
  output logic                  RES_VALID,
  output logic [`ALU_RES_W-1:0] RES,
  output logic                  ERR,
  output logic                  COUT,
  output logic                  OFLOW,
  output logic                  G,
  output logic                  L,
  output logic                  E
);

  logic                  s1_valid;
  logic                  s1_mode;
  logic [`ALU_CMD_W-1:0] s1_cmd;
  logic [`ALU_OP_W-1:0]  s1_a;
  logic [`ALU_OP_W-1:0]  s1_b;
  logic                  s1_cin;
  logic                  s1_err;
  logic [`ALU_RES_W-1:0] arith_res;
  logic                  arith_cout;
  logic                  arith_oflow;
  logic                  arith_g;
  logic                  arith_l;
  logic                  arith_e;
  logic [`ALU_RES_W-1:0] logic_res;

  alu_operand_stage u_operand_stage (
    .CLK       (CLK),
    .RST       (RST),
    .CE        (CE),
    .MODE      (MODE),
    .CMD       (CMD),
    .INP_VALID (INP_VALID),
    .OPA       (OPA),
    .OPB       (OPB),
    .CIN       (CIN),
    .s1_valid  (s1_valid),
    .s1_mode   (s1_mode),
    .s1_cmd    (s1_cmd),
    .s1_a      (s1_a),
    .s1_b      (s1_b),
    .s1_cin    (s1_cin),
    .s1_err    (s1_err)
  );

  alu_arith_unit u_arith_unit (
    .s1_cmd      (s1_cmd),
    .s1_a        (s1_a),
    .s1_b        (s1_b),
    .s1_cin      (s1_cin),
    .arith_res   (arith_res),
    .arith_cout  (arith_cout),
    .arith_oflow (arith_oflow),
    .arith_g     (arith_g),
    .arith_l     (arith_l),
    .arith_e     (arith_e)
  );

  alu_logic_unit u_logic_unit (
    .s1_cmd    (s1_cmd),
    .s1_a      (s1_a),
    .s1_b      (s1_b),
    .logic_res (logic_res)
  );

  alu_result_stage u_result_stage (
    .CLK         (CLK),
    .RST         (RST),
    .CE          (CE),
    .s1_valid    (s1_valid),
    .s1_mode     (s1_mode),
    .s1_err      (s1_err),
    .arith_res   (arith_res),
    .arith_cout  (arith_cout),
    .arith_oflow (arith_oflow),
    .arith_g     (arith_g),
    .arith_l     (arith_l),
    .arith_e     (arith_e),
    .logic_res   (logic_res),
    .RES_VALID   (RES_VALID),
    .RES         (RES),
    .ERR         (ERR),
    .COUT        (COUT),
    .OFLOW       (OFLOW),
    .G           (G),
    .L           (L),
    .E           (E)
  );

endmodule

//--- tb_alu_checker.sv
`timescale 1ns/10ps
`include "alu_defs.svh"

module tb_alu_checker (
  input logic                  CLK,
  input logic                  RST,
  input logic                  CE,
  input logic                  RES_VALID,
  input logic [`ALU_RES_W-1:0] RES,
  input logic                  ERR,
  input logic                  COUT,
  input logic                  OFLOW,
  input logic                  G,
  input logic                  L,
  input logic                  E
);

  typedef struct packed {
    logic                  valid;
    logic                  err;
    logic [`ALU_RES_W-1:0] res;
    logic                  cout;
    logic                  oflow;
    logic                  g;
    logic                  l;
    logic                  e;
  } result_t;

  result_t expect_q[$];
  result_t got;
  result_t held;      // Outputs at the previous negedge
  logic    s1_full;   // Stage 1 holds an issue
  logic    en_edge;
  logic    new_res;
  logic    rst_edge = 1'b0;   // RST seen at the last posedge
  int      n_checked = 0;
  int      n_errors = 0;

  // Operand set an opcode needs, 00 when the opcode is undefined
  function automatic logic [1:0] need_code(input logic mode, input logic [`ALU_CMD_W-1:0] cmd);
    if (mode) begin
      case (cmd)
        alu_pkg::INC_A, alu_pkg::DEC_A: return alu_pkg::NEED_A;
        alu_pkg::INC_B, alu_pkg::DEC_B: return alu_pkg::NEED_B;
        default: return (cmd <= alu_pkg::CMP) ? alu_pkg::NEED_AB : 2'b00;
      endcase
    end
    case (cmd)
      alu_pkg::NOT_A, alu_pkg::SHR1_A, alu_pkg::SHL1_A: return alu_pkg::NEED_A;
      alu_pkg::NOT_B, alu_pkg::SHR1_B, alu_pkg::SHL1_B: return alu_pkg::NEED_B;
      default: return (cmd <= alu_pkg::XNOR) ? alu_pkg::NEED_AB : 2'b00;
    endcase
  endfunction

  function automatic result_t model_result(input logic mode, input logic [`ALU_CMD_W-1:0] cmd,
      input logic [1:0] iv, input logic [`ALU_OP_W-1:0] a, input logic [`ALU_OP_W-1:0] b,
      input logic cin);
    result_t r;
    int      sum;
    r       = '0;
    r.valid = 1'b1;
    sum     = 0;
    if (need_code(mode, cmd) == 2'b00 || need_code(mode, cmd) != iv) begin
      r.err = 1'b1;
    end else if (mode) begin
      case (cmd)
        alu_pkg::ADD, alu_pkg::ADD_CIN: begin
          sum    = int'(a) + int'(b) + ((cmd == alu_pkg::ADD_CIN) ? int'(cin) : 0);
          r.cout = (sum > 255);
        end
        alu_pkg::SUB, alu_pkg::SUB_CIN: begin
          sum     = int'(a) - int'(b) - ((cmd == alu_pkg::SUB_CIN) ? int'(cin) : 0);
          r.oflow = (sum < 0);   // Borrow
        end
        alu_pkg::INC_A: sum = int'(a) + 1;
        alu_pkg::DEC_A: sum = int'(a) - 1;
        alu_pkg::INC_B: sum = int'(b) + 1;
        alu_pkg::DEC_B: sum = int'(b) - 1;
        default: begin   // CMP
          r.g = (a > b);
          r.l = (a < b);
          r.e = (a == b);
        end
      endcase
      r.res = sum[`ALU_RES_W-1:0];
      if (cmd >= alu_pkg::INC_A && cmd <= alu_pkg::DEC_B) r.oflow = r.res[`ALU_RES_W-1];
    end else begin
      case (cmd)
        alu_pkg::AND:    r.res = {1'b0, a & b};
        alu_pkg::NAND:   r.res = {1'b0, ~(a & b)};
        alu_pkg::OR:     r.res = {1'b0, a | b};
        alu_pkg::NOR:    r.res = {1'b0, ~(a | b)};
        alu_pkg::XOR:    r.res = {1'b0, a ^ b};
        alu_pkg::XNOR:   r.res = {1'b0, ~(a ^ b)};
        alu_pkg::NOT_A:  r.res = {1'b0, ~a};
        alu_pkg::NOT_B:  r.res = {1'b0, ~b};
        alu_pkg::SHR1_A: r.res = {2'b00, a[`ALU_OP_W-1:1]};
        alu_pkg::SHR1_B: r.res = {2'b00, b[`ALU_OP_W-1:1]};
        alu_pkg::SHL1_A: r.res = {a, 1'b0};   // MSB lands in the top bit
        default:         r.res = {b, 1'b0};
      endcase
    end
    return r;
  endfunction

  function automatic void push_op(input logic mode, input logic [`ALU_CMD_W-1:0] cmd,
      input logic [1:0] iv, input logic [`ALU_OP_W-1:0] a, input logic [`ALU_OP_W-1:0] b,
      input logic cin);
    expect_q.push_back(model_result(mode, cmd, iv, a, b, cin));
  endfunction

  task automatic compare_field(input string name, input logic [`ALU_RES_W-1:0] actual,
      input logic [`ALU_RES_W-1:0] expected);
    if (actual !== expected) begin
      $display("ERR %s: got 0x%h expected 0x%h at %0t", name, actual, expected, $time);
      n_errors++;
    end
  endtask

  task automatic check_result(input result_t exp);
    compare_field("RES_VALID", got.valid, exp.valid);
    compare_field("ERR", got.err, exp.err);
    compare_field("RES", got.res, exp.res);
    compare_field("COUT", got.cout, exp.cout);
    compare_field("OFLOW", got.oflow, exp.oflow);
    compare_field("G", got.g, exp.g);
    compare_field("L", got.l, exp.l);
    compare_field("E", got.e, exp.e);
  endtask

  // Track what the next output update should be
  always @(posedge CLK) begin
    rst_edge = RST;
    if (RST) begin
      s1_full = 1'b0;
      en_edge = 1'b0;
      new_res = 1'b0;
    end else begin
      en_edge = CE;
      new_res = CE && s1_full;
      if (CE) s1_full = 1'b1;
    end
  end

  always @(negedge CLK) begin
    got = {RES_VALID, ERR, RES, COUT, OFLOW, G, L, E};
    if (RST) begin
      expect_q.delete();   // Reset drops operations in flight
      if (rst_edge) check_result('0);
    end else if (new_res) begin
      if (expect_q.size() == 0) begin
        $display("Result at %0t has no issued operation behind it", $time);
        n_errors++;
      end else begin
        check_result(expect_q.pop_front());
        n_checked++;
      end
    end else if (en_edge) begin
      check_result('0);   // Empty stage 1
    end else begin
      check_result(held);   // CE low
    end
    held = got;
  end

endmodule

//--- tb_alu.sv
`timescale 1ns/10ps
`include "alu_defs.svh"

module tb_alu;

  localparam int TIMEOUT_CYCLES = 20;

  logic                  CLK;
  logic                  RST;
  logic                  CE;
  logic                  MODE;
  logic [`ALU_CMD_W-1:0] CMD;
  logic [1:0]            INP_VALID;
  logic [`ALU_OP_W-1:0]  OPA;
  logic [`ALU_OP_W-1:0]  OPB;
  logic                  CIN;
  logic                  RES_VALID;
  logic [`ALU_RES_W-1:0] RES;
  logic                  ERR;
  logic                  COUT;
  logic                  OFLOW;
  logic                  G;
  logic                  L;
  logic                  E;

  int                    n_pushed = 0;
  int                    prev_checks = 0;
  int                    prev_errors = 0;
  bit                    hung = 1'b0;
  logic                  mode;
  logic [`ALU_CMD_W-1:0] cmd;
  logic [1:0]            iv;
  logic [`ALU_OP_W-1:0]  a;

  alu_top dut0 (.*);

  tb_alu_checker chk0 (.*);

  initial begin
    CLK = 1'b0;
    forever #5 CLK = ~CLK;
  end

  // Corner values show up often enough to hit carry and borrow
  function automatic logic [`ALU_OP_W-1:0] pick_operand();
    case ($urandom_range(0, 7))
      0:       return '0;
      1:       return '1;
      default: return `ALU_OP_W'($urandom);
    endcase
  endfunction

  task automatic issue_op(input logic m, input logic [`ALU_CMD_W-1:0] c, input logic [1:0] v,
      input logic [`ALU_OP_W-1:0] opa_v, input logic [`ALU_OP_W-1:0] opb_v);
    logic cin_v;
    cin_v = 1'($urandom_range(0, 1));
    @(posedge CLK);
    CE        <= 1'b1;
    MODE      <= m;
    CMD       <= c;
    INP_VALID <= v;
    OPA       <= opa_v;
    OPB       <= opb_v;
    CIN       <= cin_v;
    chk0.push_op(m, c, v, opa_v, opb_v, cin_v);
    n_pushed++;
  endtask

  task automatic issue_random_op();
    logic                  m;
    logic [`ALU_CMD_W-1:0] c;
    logic [1:0]            v;
    m = 1'($urandom_range(0, 1));
    c = `ALU_CMD_W'($urandom_range(0, 15));
    v = chk0.need_code(m, c);
    if ($urandom_range(0, 3) == 0) v = 2'($urandom_range(0, 3));
    issue_op(m, c, v, pick_operand(), pick_operand());
  endtask

  task automatic idle_cycle();
    @(posedge CLK);
    CE  <= 1'b0;
    CMD <= `ALU_CMD_W'($urandom);   // Inputs move while CE is low
    OPA <= `ALU_OP_W'($urandom);
    OPB <= `ALU_OP_W'($urandom);
  endtask

  task automatic apply_reset();
    @(posedge CLK);
    CE  <= 1'b0;
    RST <= 1'b1;
    repeat (2) @(posedge CLK);
    RST <= 1'b0;
  endtask

  // Every enabled edge issues, so keep the pipe moving with fresh ops
  task automatic wait_results(input int target);
    int waited;
    waited = 0;
    while (chk0.n_checked < target && waited < TIMEOUT_CYCLES) begin
      issue_random_op();
      waited++;
    end
    if (chk0.n_checked < target) begin
      $display("Timeout: %0d results never arrived", target - chk0.n_checked);
      hung = 1'b1;
    end
  endtask

  task automatic report_test(input string name);
    $display("test %-10s %0d results checked, %0d errors", name,
             chk0.n_checked - prev_checks, chk0.n_errors - prev_errors);
    prev_checks = chk0.n_checked;
    prev_errors = chk0.n_errors;
  endtask

  task automatic finish_test(input string name);
    wait_results(n_pushed);
    report_test(name);
  endtask

  initial begin
    void'($urandom(56092));
    RST       = 1'b1;
    CE        = 1'b0;
    MODE      = 1'b0;
    CMD       = '0;
    INP_VALID = '0;
    OPA       = '0;
    OPB       = '0;
    CIN       = 1'b0;
    apply_reset();

    repeat (64) begin
      cmd = `ALU_CMD_W'($urandom_range(0, int'(alu_pkg::DEC_B)));
      issue_op(1'b1, cmd, chk0.need_code(1'b1, cmd), pick_operand(), pick_operand());
    end
    finish_test("arith");

    repeat (32) begin
      a = pick_operand();
      issue_op(1'b1, alu_pkg::CMP, alu_pkg::NEED_AB, a,
               ($urandom_range(0, 1) == 1) ? a : pick_operand());
    end
    finish_test("cmp");

    for (int c = 0; c <= int'(alu_pkg::SHL1_B); c++) begin
      cmd = `ALU_CMD_W'(c);
      repeat (6) issue_op(1'b0, cmd, chk0.need_code(1'b0, cmd), pick_operand(), pick_operand());
    end
    finish_test("logic");

    repeat (40) begin
      mode = 1'($urandom_range(0, 1));
      if ($urandom_range(0, 1) == 1) begin
        cmd = `ALU_CMD_W'(mode ? $urandom_range(9, 15) : $urandom_range(12, 15));
        iv  = 2'($urandom_range(0, 3));
      end else begin
        cmd = `ALU_CMD_W'(mode ? $urandom_range(0, 8) : $urandom_range(0, 11));
        iv  = chk0.need_code(mode, cmd) ^ 2'($urandom_range(1, 3));   // Never the right set
      end
      issue_op(mode, cmd, iv, pick_operand(), pick_operand());
    end
    finish_test("errors");

    repeat (100) issue_random_op();
    finish_test("pipeline");

    repeat (120) begin
      if ($urandom_range(0, 2) == 0) begin
        idle_cycle();
      end else begin
        issue_random_op();
      end
    end
    finish_test("ce_toggle");

    apply_reset();
    repeat (4) idle_cycle();
    report_test("reset");

    $display("total: %0d results checked, %0d errors, %0d timeouts", chk0.n_checked,
             chk0.n_errors, int'(hung));
    if (chk0.n_errors == 0 && !hung) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

//--- alu.f
+incdir+.
alu_pkg.sv
alu_operand_stage.sv
alu_arith_unit.sv
alu_logic_unit.sv
alu_result_stage.sv
alu_top.sv
tb_alu_checker.sv
tb_alu.sv

//--- Makefile
VERILATOR ?= verilator
FILELIST  ?= alu.f
TB_TOP    ?= tb_alu
LINT_TOP  ?= alu_top
OBJ_DIR   ?= obj_dir
SIM_FLAGS ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= TESTBENCH PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(LINT_TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TB_TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TB_TOP) | tee /dev/stderr | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
